//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_udp_echo
FILELIST  ?= sources.f

.PHONY: all lint clean

all:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test passed"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- rtl/axis_payload_fifo.sv
// ====================
// Payload FIFO
// First-word-fall-through, keep/last/user per beat
// ====================

`default_nettype none

module axis_payload_fifo #(
    parameter int DEPTH = 16
) (
    input  logic                                clk,
    input  logic                                rst,
    input  axis_word_pkg::payload_word_t        s_tdata,
    input  logic [axis_word_pkg::KEEP_W-1:0]    s_tkeep,
    input  logic                                s_tvalid,
    output logic                                s_tready,
    input  logic                                s_tlast,
    input  logic                                s_tuser,
    output axis_word_pkg::payload_word_t        m_tdata,
    output logic [axis_word_pkg::KEEP_W-1:0]    m_tkeep,
    output logic                                m_tvalid,
    input  logic                                m_tready,
    output logic                                m_tlast,
    output logic                                m_tuser
);
    import axis_word_pkg::*;

    localparam int ADDR_W = $clog2(DEPTH);
    localparam logic [ADDR_W:0] FULL_COUNT = (ADDR_W + 1)'(DEPTH);

    payload_word_t     data_mem [DEPTH];
    logic [KEEP_W-1:0] keep_mem [DEPTH];
    logic              last_mem [DEPTH];
    logic              user_mem [DEPTH];

    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   count;
    logic              push;
    logic              pop;

    assign s_tready = (count != FULL_COUNT);
    assign m_tvalid = (count != '0);
    assign push     = s_tvalid && s_tready;
    assign pop      = m_tvalid && m_tready;

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= s_tdata;
            keep_mem[wr_ptr] <= s_tkeep;
            last_mem[wr_ptr] <= s_tlast;
            user_mem[wr_ptr] <= s_tuser;
        end
    end

    // Pointers wrap on their own, DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head of queue shown without a read request
    assign m_tdata = data_mem[rd_ptr];
    assign m_tkeep = keep_mem[rd_ptr];
    assign m_tlast = last_mem[rd_ptr];
    assign m_tuser = user_mem[rd_ptr];

endmodule

`default_nettype wire

//--- rtl/axis_word_pkg.sv
// ====================
// Payload stream word types
// Widths and the 64-bit payload word
// ====================

`default_nettype none

package axis_word_pkg;

    localparam int DATA_W = 64;
    localparam int KEEP_W = 8;

    // Same word as one raw value or as byte lanes
    typedef union packed {
        logic [DATA_W-1:0]      raw;
        logic [KEEP_W-1:0][7:0] lane;
    } payload_word_t;

endpackage

`default_nettype wire

//--- rtl/led_first_byte.sv
// ====================
// First payload byte to LEDs
// ====================

`default_nettype none

module led_first_byte (
    input  logic                         clk,
    input  logic                         rst,
    input  axis_word_pkg::payload_word_t tdata,
    input  logic                         tvalid,
    input  logic                         tlast,
    output logic [7:0]                   led
);
    logic mid_frame;

    always_ff @(posedge clk) begin
        if (rst) begin
            mid_frame <= 1'b0;
            led       <= 8'h00;
        end else if (tvalid) begin
            // Frame start, take lane 0
            if (!mid_frame) begin
                led       <= tdata.lane[0];
                mid_frame <= 1'b1;
            end
            if (tlast) begin
                mid_frame <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/udp_echo_cfg_pkg.sv
// ====================
// Echo service constants
// Addresses, port and reply TTL
// ====================

`default_nettype none

package udp_echo_cfg_pkg;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // 192.168.1.128
    localparam ip_addr_t LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

    localparam udp_port_t ECHO_PORT_DEFAULT = 16'd1234;

    // Reply time-to-live
    localparam logic [7:0] REPLY_TTL = 8'd64;

endpackage

`default_nettype wire

//--- rtl/udp_echo_top.sv
// ====================
// UDP echo service top
// Port filter, payload FIFO and LED capture
// ====================

`default_nettype none

module udp_echo_top #(
    parameter udp_echo_cfg_pkg::udp_port_t ECHO_PORT = udp_echo_cfg_pkg::ECHO_PORT_DEFAULT,
    parameter int                          DEPTH     = 16
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rx_hdr_valid,
    output logic                                rx_hdr_ready,
    input  udp_echo_cfg_pkg::ip_addr_t          rx_src_ip,
    input  udp_echo_cfg_pkg::udp_port_t         rx_src_port,
    input  udp_echo_cfg_pkg::udp_port_t         rx_dst_port,
    input  udp_echo_cfg_pkg::udp_port_t         rx_length,
    output logic                                tx_hdr_valid,
    input  logic                                tx_hdr_ready,
    output udp_echo_cfg_pkg::ip_addr_t          tx_src_ip,
    output udp_echo_cfg_pkg::ip_addr_t          tx_dst_ip,
    output udp_echo_cfg_pkg::udp_port_t         tx_src_port,
    output udp_echo_cfg_pkg::udp_port_t         tx_dst_port,
    output udp_echo_cfg_pkg::udp_port_t         tx_length,
    output udp_echo_cfg_pkg::udp_port_t         tx_checksum,
    output logic [7:0]                          tx_ttl,
    output logic [5:0]                          tx_dscp,
    output logic [1:0]                          tx_ecn,
    input  logic [axis_word_pkg::DATA_W-1:0]    rx_pl_tdata,
    input  logic [axis_word_pkg::KEEP_W-1:0]    rx_pl_tkeep,
    input  logic                                rx_pl_tvalid,
    output logic                                rx_pl_tready,
    input  logic                                rx_pl_tlast,
    input  logic                                rx_pl_tuser,
    output logic [axis_word_pkg::DATA_W-1:0]    tx_pl_tdata,
    output logic [axis_word_pkg::KEEP_W-1:0]    tx_pl_tkeep,
    output logic                                tx_pl_tvalid,
    input  logic                                tx_pl_tready,
    output logic                                tx_pl_tlast,
    output logic                                tx_pl_tuser,
    output logic [7:0]                          led
);
    import axis_word_pkg::*;

    // Filter to FIFO
    payload_word_t     fwd_tdata;
    logic [KEEP_W-1:0] fwd_tkeep;
    logic              fwd_tvalid;
    logic              fwd_tready;
    logic              fwd_tlast;
    logic              fwd_tuser;

    // Output beat actually taken by the sink
    logic tx_pl_fire;

    assign tx_pl_fire = tx_pl_tvalid && tx_pl_tready;

    udp_port_filter #(
        .ECHO_PORT(ECHO_PORT)
    ) u_filter (
        .*
    );

    axis_payload_fifo #(
        .DEPTH(DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rst      (rst),
        .s_tdata  (fwd_tdata),
        .s_tkeep  (fwd_tkeep),
        .s_tvalid (fwd_tvalid),
        .s_tready (fwd_tready),
        .s_tlast  (fwd_tlast),
        .s_tuser  (fwd_tuser),
        .m_tdata  (tx_pl_tdata),
        .m_tkeep  (tx_pl_tkeep),
        .m_tvalid (tx_pl_tvalid),
        .m_tready (tx_pl_tready),
        .m_tlast  (tx_pl_tlast),
        .m_tuser  (tx_pl_tuser)
    );

    // Stalled last beat must not end the frame early
    led_first_byte u_led (
        .clk    (clk),
        .rst    (rst),
        .tdata  (tx_pl_tdata),
        .tvalid (tx_pl_fire),
        .tlast  (tx_pl_tlast),
        .led    (led)
    );

endmodule

`default_nettype wire

//--- rtl/udp_port_filter.sv
// ====================
// UDP echo port filter
// Builds the reply header, steers or drops payload
// ====================

`default_nettype none

module udp_port_filter #(
    parameter udp_echo_cfg_pkg::udp_port_t ECHO_PORT = udp_echo_cfg_pkg::ECHO_PORT_DEFAULT
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rx_hdr_valid,
    output logic                                rx_hdr_ready,
    input  udp_echo_cfg_pkg::ip_addr_t          rx_src_ip,
    input  udp_echo_cfg_pkg::udp_port_t         rx_src_port,
    input  udp_echo_cfg_pkg::udp_port_t         rx_dst_port,
    input  udp_echo_cfg_pkg::udp_port_t         rx_length,
    output logic                                tx_hdr_valid,
    input  logic                                tx_hdr_ready,
    output udp_echo_cfg_pkg::ip_addr_t          tx_src_ip,
    output udp_echo_cfg_pkg::ip_addr_t          tx_dst_ip,
    output udp_echo_cfg_pkg::udp_port_t         tx_src_port,
    output udp_echo_cfg_pkg::udp_port_t         tx_dst_port,
    output udp_echo_cfg_pkg::udp_port_t         tx_length,
    output udp_echo_cfg_pkg::udp_port_t         tx_checksum,
    output logic [7:0]                          tx_ttl,
    output logic [5:0]                          tx_dscp,
    output logic [1:0]                          tx_ecn,
    input  axis_word_pkg::payload_word_t        rx_pl_tdata,
    input  logic [axis_word_pkg::KEEP_W-1:0]    rx_pl_tkeep,
    input  logic                                rx_pl_tvalid,
    output logic                                rx_pl_tready,
    input  logic                                rx_pl_tlast,
    input  logic                                rx_pl_tuser,
    output axis_word_pkg::payload_word_t        fwd_tdata,
    output logic [axis_word_pkg::KEEP_W-1:0]    fwd_tkeep,
    output logic                                fwd_tvalid,
    input  logic                                fwd_tready,
    output logic                                fwd_tlast,
    output logic                                fwd_tuser
);
    import udp_echo_cfg_pkg::*;

    logic match_cond;
    logic match_reg;
    logic drop_reg;

    assign match_cond = (rx_dst_port == ECHO_PORT);

    // Header passes straight through on a match, else is swallowed
    assign tx_hdr_valid = rx_hdr_valid && match_cond;
    assign rx_hdr_ready = (tx_hdr_ready && match_cond) || !match_cond;

    assign tx_src_ip   = LOCAL_IP;
    assign tx_dst_ip   = rx_src_ip;
    assign tx_src_port = rx_dst_port;
    assign tx_dst_port = rx_src_port;
    assign tx_length   = rx_length;
    assign tx_checksum = '0;
    assign tx_ttl      = REPLY_TTL;
    assign tx_dscp     = '0;
    assign tx_ecn      = '0;

    // Decision taken at frame start, reloaded after the last beat
    always_ff @(posedge clk) begin
        if (rst) begin
            match_reg <= 1'b0;
            drop_reg  <= 1'b0;
        end else if (rx_pl_tvalid) begin
            if ((!match_reg && !drop_reg) || (rx_pl_tready && rx_pl_tlast)) begin
                match_reg <= match_cond;
                drop_reg  <= !match_cond;
            end
        end else begin
            match_reg <= 1'b0;
            drop_reg  <= 1'b0;
        end
    end

    assign fwd_tdata  = rx_pl_tdata;
    assign fwd_tkeep  = rx_pl_tkeep;
    assign fwd_tvalid = rx_pl_tvalid && match_reg;
    assign fwd_tlast  = rx_pl_tlast;
    assign fwd_tuser  = rx_pl_tuser;

    // Dropped frames are always accepted
    assign rx_pl_tready = (fwd_tready && match_reg) || drop_reg;

endmodule

`default_nettype wire

//--- sources.f
rtl/udp_echo_cfg_pkg.sv
rtl/axis_word_pkg.sv
rtl/udp_port_filter.sv
rtl/axis_payload_fifo.sv
rtl/led_first_byte.sv
rtl/udp_echo_top.sv
testbench/udp_echo_sva.sv
testbench/udp_echo_checker.sv
testbench/tb_udp_echo.sv

//--- testbench/tb_udp_echo.sv
// ====================
// UDP echo testbench
// Table-driven datagrams, random back-pressure
// ====================

`default_nettype none

module tb_udp_echo;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [15:0] ECHO_PORT = 16'd1234;
    localparam int NUM = 8;
    localparam int MAX_BEATS = 8;
    localparam int LIMIT_CYCLES = NUM * MAX_BEATS * 40 + 16;

    // dst_port, src_ip, src_port, beats, first byte, last keep, tuser, random ready
    localparam logic [89:0] STIM [NUM] = '{
        {16'd1234, 32'hc0a80105, 16'd5000, 8'd4, 8'h10, 8'hff, 1'b0, 1'b0},
        {16'd4321, 32'hc0a80106, 16'd5001, 8'd3, 8'h20, 8'h0f, 1'b0, 1'b0},
        {16'd1234, 32'hc0a80107, 16'd5002, 8'd1, 8'h30, 8'h01, 1'b1, 1'b0},
        {16'd1234, 32'h0a000001, 16'd6000, 8'd8, 8'h40, 8'h3f, 1'b0, 1'b1},
        {16'd80,   32'h0a000002, 16'd6001, 8'd5, 8'h50, 8'hff, 1'b1, 1'b1},
        {16'd1234, 32'h0a000003, 16'd6002, 8'd6, 8'h60, 8'h7f, 1'b1, 1'b1},
        {16'd1234, 32'h0a000004, 16'd6003, 8'd7, 8'h70, 8'hff, 1'b0, 1'b1},
        {16'd1234, 32'h0a000005, 16'd6004, 8'd2, 8'h80, 8'h03, 1'b0, 1'b1}
    };

    logic clk, rst;
    logic rx_hdr_valid, rx_hdr_ready, tx_hdr_valid, tx_hdr_ready;
    logic [31:0] rx_src_ip, tx_src_ip, tx_dst_ip;
    logic [15:0] rx_src_port, rx_dst_port, rx_length;
    logic [15:0] tx_src_port, tx_dst_port, tx_length, tx_checksum;
    logic [7:0]  tx_ttl, led, rx_pl_tkeep, tx_pl_tkeep;
    logic [5:0]  tx_dscp;
    logic [1:0]  tx_ecn;
    logic [63:0] rx_pl_tdata, tx_pl_tdata;
    logic rx_pl_tvalid, rx_pl_tready, rx_pl_tlast, rx_pl_tuser;
    logic tx_pl_tvalid, tx_pl_tready, tx_pl_tlast, tx_pl_tuser;
    logic random_ready;
    int   hdr_errors, pl_errors, led_errors, pending;

    udp_echo_top #(.ECHO_PORT(ECHO_PORT), .DEPTH(16)) uut (.*);

    udp_echo_checker #(.ECHO_PORT(ECHO_PORT)) u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        tx_hdr_ready <= random_ready ? 1'($urandom) : 1'b1;
        tx_pl_tready <= random_ready ? 1'($urandom) : 1'b1;
    end

    initial begin
        #(LIMIT_CYCLES * 8);
        $display("Timeout, the DUT stopped moving datagrams");
        $display("Test failed");
        $finish;
    end

    task automatic send_datagram(input logic [89:0] e);
        logic [7:0] beats;
        logic [7:0] val;
        beats = e[25:18];
        @(posedge clk);
        random_ready <= e[0];
        rx_dst_port  <= e[89:74];
        rx_src_ip    <= e[73:42];
        rx_src_port  <= e[41:26];
        rx_length    <= 16'(8 + 8 * beats);
        rx_hdr_valid <= 1'b1;
        do @(posedge clk); while (!rx_hdr_ready);
        rx_hdr_valid <= 1'b0;
        for (int b = 0; b < beats; b++) begin
            val = e[17:10] + 8'(b);
            rx_pl_tdata  <= {{7{val}} ^ 56'h0123456789abcd, val};
            rx_pl_tkeep  <= (b == beats - 1) ? e[9:2] : 8'hff;
            rx_pl_tlast  <= (b == beats - 1);
            rx_pl_tuser  <= e[1];
            rx_pl_tvalid <= 1'b1;
            do @(posedge clk); while (!rx_pl_tready);
        end
        rx_pl_tvalid <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        void'($urandom(32'hdec3));
        rst = 1'b1;
        random_ready = 1'b0;
        rx_hdr_valid = 1'b0;
        rx_src_ip = '0;
        rx_src_port = '0;
        rx_dst_port = '0;
        rx_length = '0;
        rx_pl_tdata = '0;
        rx_pl_tkeep = '0;
        rx_pl_tvalid = 1'b0;
        rx_pl_tlast = 1'b0;
        rx_pl_tuser = 1'b0;
        tx_hdr_ready = 1'b1;
        tx_pl_tready = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < NUM; i++) begin
            send_datagram(STIM[i]);
        end
        while (pending != 0) @(posedge clk);
        repeat (20) @(posedge clk);
        $display("Errors: header %0d, payload %0d, led %0d",
            hdr_errors, pl_errors, led_errors);
        if (hdr_errors + pl_errors + led_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/udp_echo_checker.sv
// ====================
// Echo reply scoreboard
// Predicts headers, beats and LEDs from rx traffic
// ====================

`default_nettype none

module udp_echo_checker #(
    parameter logic [15:0] ECHO_PORT = 16'd1234
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        rx_hdr_valid,
    input  logic        rx_hdr_ready,
    input  logic [31:0] rx_src_ip,
    input  logic [15:0] rx_src_port,
    input  logic [15:0] rx_dst_port,
    input  logic [15:0] rx_length,
    input  logic        tx_hdr_valid,
    input  logic        tx_hdr_ready,
    input  logic [31:0] tx_src_ip,
    input  logic [31:0] tx_dst_ip,
    input  logic [15:0] tx_src_port,
    input  logic [15:0] tx_dst_port,
    input  logic [15:0] tx_length,
    input  logic [15:0] tx_checksum,
    input  logic [7:0]  tx_ttl,
    input  logic [5:0]  tx_dscp,
    input  logic [1:0]  tx_ecn,
    input  logic [63:0] rx_pl_tdata,
    input  logic [7:0]  rx_pl_tkeep,
    input  logic        rx_pl_tvalid,
    input  logic        rx_pl_tready,
    input  logic        rx_pl_tlast,
    input  logic        rx_pl_tuser,
    input  logic [63:0] tx_pl_tdata,
    input  logic [7:0]  tx_pl_tkeep,
    input  logic        tx_pl_tvalid,
    input  logic        tx_pl_tready,
    input  logic        tx_pl_tlast,
    input  logic        tx_pl_tuser,
    input  logic [7:0]  led,
    output int          hdr_errors,
    output int          pl_errors,
    output int          led_errors,
    output int          pending
);
    timeunit 1ns;
    timeprecision 1ps;

    // 192.168.1.128, TTL 64, DSCP and ECN zero
    localparam logic [47:0] REPLY_CONST = {32'hc0a80180, 8'd64, 6'd0, 2'd0};

    logic [95:0] hdr_q [$];
    logic [73:0] beat_q [$];
    logic [95:0] hdr_exp;
    logic [73:0] beat_exp;
    logic [7:0]  led_exp;
    logic        tx_first;

    initial begin
        hdr_errors = 0;
        pl_errors = 0;
        led_errors = 0;
        pending = 0;
    end

    always @(posedge clk) begin
        if (rst) begin
            led_exp  <= 8'h00;
            tx_first <= 1'b1;
        end else begin
            if (led !== led_exp) begin
                $display("MISMATCH led exp=%h got=%h", led_exp, led);
                led_errors++;
            end
            if (rx_hdr_valid && rx_hdr_ready && rx_dst_port == ECHO_PORT) begin
                hdr_q.push_back({rx_src_ip, rx_dst_port, rx_src_port, rx_length, 16'h0});
            end
            if (rx_pl_tvalid && rx_pl_tready && rx_dst_port == ECHO_PORT) begin
                beat_q.push_back({rx_pl_tdata, rx_pl_tkeep, rx_pl_tlast, rx_pl_tuser});
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (hdr_q.size() == 0) begin
                    $display("Reply header sent with no echo datagram received");
                    hdr_errors++;
                end else begin
                    hdr_exp = hdr_q.pop_front();
                    if ({tx_dst_ip, tx_src_port, tx_dst_port, tx_length, tx_checksum}
                            !== hdr_exp) begin
                        $display("MISMATCH tx_hdr exp=%h got=%h", hdr_exp,
                            {tx_dst_ip, tx_src_port, tx_dst_port, tx_length, tx_checksum});
                        hdr_errors++;
                    end
                    if ({tx_src_ip, tx_ttl, tx_dscp, tx_ecn} !== REPLY_CONST) begin
                        $display("MISMATCH tx_src_ip/ttl/dscp/ecn exp=%h got=%h", REPLY_CONST,
                            {tx_src_ip, tx_ttl, tx_dscp, tx_ecn});
                        hdr_errors++;
                    end
                end
            end
            if (tx_pl_tvalid && tx_pl_tready) begin
                if (beat_q.size() == 0) begin
                    $display("Payload beat sent that was never received for echo");
                    pl_errors++;
                end else begin
                    beat_exp = beat_q.pop_front();
                    // LED shows the low byte of each frame's first beat
                    if (tx_first) begin
                        led_exp <= beat_exp[17:10];
                    end
                    tx_first <= beat_exp[1];
                    if ({tx_pl_tdata, tx_pl_tkeep, tx_pl_tlast, tx_pl_tuser} !== beat_exp) begin
                        $display("MISMATCH tx_pl exp=%h got=%h", beat_exp,
                            {tx_pl_tdata, tx_pl_tkeep, tx_pl_tlast, tx_pl_tuser});
                        pl_errors++;
                    end
                end
            end
            pending <= hdr_q.size() + beat_q.size();
        end
    end

endmodule

`default_nettype wire

//--- testbench/udp_echo_sva.sv
// ====================
// Handshake and reset assertions
// ====================

`default_nettype none

module udp_echo_sva #(
    parameter udp_echo_cfg_pkg::udp_port_t ECHO_PORT = udp_echo_cfg_pkg::ECHO_PORT_DEFAULT
) (
    input logic        clk,
    input logic        rst,
    input logic [15:0] rx_dst_port,
    input logic        tx_hdr_valid,
    input logic        tx_hdr_ready,
    input logic [31:0] tx_dst_ip,
    input logic [15:0] tx_src_port,
    input logic [15:0] tx_dst_port,
    input logic [15:0] tx_length,
    input logic [63:0] tx_pl_tdata,
    input logic [7:0]  tx_pl_tkeep,
    input logic        tx_pl_tvalid,
    input logic        tx_pl_tready,
    input logic        tx_pl_tlast,
    input logic        tx_pl_tuser,
    input logic        rx_pl_tready
);
    timeunit 1ns;
    timeprecision 1ps;

    a_reset_idle: assert property (@(posedge clk)
        rst |=> !tx_hdr_valid && !tx_pl_tvalid && !rx_pl_tready)
        else $error("outputs active in the cycle after reset");

    a_hdr_hold: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid
            && $stable({tx_dst_ip, tx_src_port, tx_dst_port, tx_length}))
        else $error("reply header changed while stalled");

    a_pl_hold: assert property (@(posedge clk) disable iff (rst)
        tx_pl_tvalid && !tx_pl_tready |=> tx_pl_tvalid
            && $stable({tx_pl_tdata, tx_pl_tkeep, tx_pl_tlast, tx_pl_tuser}))
        else $error("payload beat changed while stalled");

    a_hdr_port: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid |-> rx_dst_port == ECHO_PORT)
        else $error("reply header for a foreign port");

endmodule

bind udp_echo_top udp_echo_sva #(.ECHO_PORT(ECHO_PORT)) u_sva (.*);

`default_nettype wire
